//--- source/spi_flash_pkg.sv
package spi_flash_pkg;

  // One APB or Wishbone data word
  typedef logic [31:0] apb_data_t;

  // Wishbone classic request, master to slave
  typedef struct packed {
    logic [4:0] adr;
    apb_data_t  dat;
    logic [3:0] sel;
    logic       we;
    logic       stb;
    logic       cyc;
  } wb_req_t;

  // Wishbone classic response, slave to master
  typedef struct packed {
    apb_data_t dat;
    logic      ack;
    logic      err;
  } wb_rsp_t;

  // Command from the register file to the shift engine
  typedef struct packed {
    logic        go;        // single-cycle start strobe
    logic [6:0]  char_len;  // zero selects 64 bits
    logic [15:0] divider;
    logic [63:0] tx_data;
  } spi_cmd_t;

  // Status from the shift engine back to the register file
  typedef struct packed {
    logic        busy;
    logic        done;      // single-cycle end strobe
    logic [63:0] rx_data;
  } spi_stat_t;

  // Register offsets on the 5-bit Wishbone address
  localparam logic [4:0] REG_RX0_TX0 = 5'h00;
  localparam logic [4:0] REG_RX1_TX1 = 5'h04;
  localparam logic [4:0] REG_CTRL    = 5'h10;
  localparam logic [4:0] REG_DIVIDER = 5'h14;
  localparam logic [4:0] REG_SS      = 5'h18;

  // CTRL bit positions
  localparam int CTRL_GO_BSY = 8;
  localparam int CTRL_IE     = 12;
  // Width of the character length field at bits 6:0
  localparam int CTRL_CHAR_LEN = 7;

  // Serial flash slow read opcode
  localparam logic [7:0] FLASH_READ_CMD = 8'h03;

endpackage

//--- source/apb_front.sv
`timescale 1ns/1ps

module apb_front #(
  parameter spi_flash_pkg::apb_data_t FLASH_BASE = 32'h3000_0000,
  parameter spi_flash_pkg::apb_data_t FLASH_END  = 32'h3FFF_FFFF,
  parameter spi_flash_pkg::apb_data_t SPI_BASE   = 32'h1000_1000,
  parameter spi_flash_pkg::apb_data_t SPI_END    = 32'h1000_1FFF
) (
  input  logic                     clock,
  input  logic                     reset,
  input  spi_flash_pkg::apb_data_t paddr_i,
  input  spi_flash_pkg::apb_data_t pwdata_i,
  input  logic                     psel_i,
  input  logic                     penable_i,
  input  logic                     pwrite_i,
  input  logic [3:0]               pstrb_i,
  output spi_flash_pkg::apb_data_t prdata_o,
  output logic                     pready_o,
  output logic                     pslverr_o,
  output spi_flash_pkg::wb_req_t   wb_req_o,
  input  spi_flash_pkg::wb_rsp_t   wb_rsp_i,
  output logic                     xip_req_o,
  output logic [23:0]              xip_addr_o,
  input  spi_flash_pkg::wb_req_t   seq_req_i,
  input  logic                     xip_done_i,
  input  spi_flash_pkg::apb_data_t xip_data_i
);
  import spi_flash_pkg::*;

  // Which path owns the transfer in flight
  typedef enum logic [1:0] {F_IDLE, F_WB, F_XIP, F_RESP} front_state_t;

  front_state_t state_q;
  apb_data_t    spi_off;
  apb_data_t    prdata_q;
  logic         access;
  logic         in_flash;
  logic         spi_hit;
  logic         err_q;
  logic         direct;

  assign access   = psel_i && penable_i;
  assign in_flash = (paddr_i >= FLASH_BASE) && (paddr_i <= FLASH_END);
  // Register set only covers the first 32 bytes of the window
  assign spi_off  = paddr_i - SPI_BASE;
  assign spi_hit  = (paddr_i >= SPI_BASE) && (paddr_i <= SPI_END) && (spi_off < 32'd32);

  // Direct path drives Wishbone from the start of the access phase
  assign direct = (state_q == F_WB) || (state_q == F_IDLE && access && spi_hit);

  always_comb begin
    wb_req_o = '0;
    if (state_q == F_XIP) begin
      wb_req_o = seq_req_i;
    end else if (direct) begin
      wb_req_o.adr = paddr_i[4:0];
      wb_req_o.dat = pwdata_i;
      // APB reads carry no strobes, Wishbone wants all lanes
      wb_req_o.sel = pwrite_i ? pstrb_i : 4'hF;
      wb_req_o.we  = pwrite_i;
      wb_req_o.stb = 1'b1;
      wb_req_o.cyc = 1'b1;
    end
  end

  // Flash reads kick the sequencer once
  assign xip_req_o  = (state_q == F_IDLE) && access && !spi_hit && in_flash && !pwrite_i;
  assign xip_addr_o = paddr_i[23:0];

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      state_q <= F_IDLE;
      err_q   <= 1'b0;
    end else begin
      case (state_q)
        F_IDLE: begin
          if (access) begin
            err_q <= 1'b0;
            if (spi_hit) begin
              state_q <= F_WB;
            end else if (in_flash && !pwrite_i) begin
              state_q <= F_XIP;
            end else begin
              // Out of window or flash write
              state_q <= F_RESP;
              err_q   <= 1'b1;
            end
          end
        end
        F_WB: begin
          if (wb_rsp_i.ack || wb_rsp_i.err) begin
            err_q   <= wb_rsp_i.err;
            state_q <= F_RESP;
          end
        end
        F_XIP: begin
          if (xip_done_i) state_q <= F_RESP;
        end
        default: state_q <= F_IDLE;
      endcase
    end
  end

  // Read word capture
  always_ff @(posedge clock) begin
    if (state_q == F_WB && (wb_rsp_i.ack || wb_rsp_i.err)) begin
      prdata_q <= wb_rsp_i.dat;
    end else if (state_q == F_XIP && xip_done_i) begin
      prdata_q <= xip_data_i;
    end
  end

  assign prdata_o  = prdata_q;
  assign pready_o  = (state_q == F_RESP);
  assign pslverr_o = (state_q == F_RESP) && err_q;

  // Completion only lands inside an access phase
  a_pready_in_access: assert property (
    @(posedge clock) disable iff (reset) pready_o |-> (psel_i && penable_i)
  );

endmodule

//--- source/xip_sequencer.sv
`timescale 1ns/1ps

module xip_sequencer #(
  parameter int unsigned XIP_DIVIDER = 1
) (
  input  logic                     clock,
  input  logic                     reset,
  input  logic                     xip_req_i,
  input  logic [23:0]              xip_addr_i,
  output spi_flash_pkg::wb_req_t   wb_req_o,
  input  spi_flash_pkg::wb_rsp_t   wb_rsp_i,
  output logic                     xip_done_o,
  output spi_flash_pkg::apb_data_t xip_data_o
);
  import spi_flash_pkg::*;

  // One state per register access of the read sequence
  typedef enum logic [2:0] {
    S_IDLE,
    S_TX1,
    S_DIV,
    S_SS,
    S_GO,
    S_POLL,
    S_RX0,
    S_SSCLR
  } seq_state_t;

  seq_state_t  state_q;
  seq_state_t  next_state;
  logic [23:0] addr_q;
  apb_data_t   data_q;
  logic        stb_q;
  logic        done_q;
  logic        rsp;

  // Error is treated like ack so the sequence never hangs
  assign rsp = stb_q && (wb_rsp_i.ack || wb_rsp_i.err);

  // Request contents follow the state and the strobe is registered
  always_comb begin
    wb_req_o     = '0;
    wb_req_o.sel = 4'hF;
    wb_req_o.stb = stb_q;
    wb_req_o.cyc = stb_q;
    next_state   = S_IDLE;
    case (state_q)
      S_TX1: begin
        // Opcode and address lead the 64-bit frame
        wb_req_o.adr = REG_RX1_TX1;
        wb_req_o.dat = {FLASH_READ_CMD, addr_q};
        wb_req_o.we  = 1'b1;
        next_state   = S_DIV;
      end
      S_DIV: begin
        wb_req_o.adr       = REG_DIVIDER;
        wb_req_o.dat[15:0] = 16'(XIP_DIVIDER);
        wb_req_o.we        = 1'b1;
        next_state         = S_SS;
      end
      S_SS: begin
        // Flash sits on slave select 0
        wb_req_o.adr = REG_SS;
        wb_req_o.dat = 32'd1;
        wb_req_o.we  = 1'b1;
        next_state   = S_GO;
      end
      S_GO: begin
        wb_req_o.adr                    = REG_CTRL;
        wb_req_o.dat[CTRL_CHAR_LEN-1:0] = 7'd64;
        wb_req_o.dat[CTRL_GO_BSY]       = 1'b1;
        wb_req_o.we                     = 1'b1;
        next_state                      = S_POLL;
      end
      S_POLL: begin
        wb_req_o.adr = REG_CTRL;
        // Stay here while the busy bit reads back set
        next_state   = wb_rsp_i.dat[CTRL_GO_BSY] ? S_POLL : S_RX0;
      end
      S_RX0: begin
        wb_req_o.adr = REG_RX0_TX0;
        next_state   = S_SSCLR;
      end
      S_SSCLR: begin
        wb_req_o.adr = REG_SS;
        wb_req_o.we  = 1'b1;
        next_state   = S_IDLE;
      end
      default: next_state = S_IDLE;
    endcase
  end

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      state_q <= S_IDLE;
      stb_q   <= 1'b0;
      done_q  <= 1'b0;
    end else begin
      done_q <= 1'b0;
      if (state_q == S_IDLE) begin
        if (xip_req_i) state_q <= S_TX1;
      end else if (rsp) begin
        // Drop strobe for a cycle after every ack
        stb_q   <= 1'b0;
        state_q <= next_state;
        if (state_q == S_SSCLR) done_q <= 1'b1;
      end else begin
        stb_q <= 1'b1;
      end
    end
  end

  // Address and result words
  always_ff @(posedge clock) begin
    if (state_q == S_IDLE && xip_req_i) addr_q <= xip_addr_i;
    if (state_q == S_RX0 && rsp) data_q <= wb_rsp_i.dat;
  end

  assign xip_done_o = done_q;
  assign xip_data_o = data_q;

  // Front end only asks again once the sequence has finished
  a_req_when_idle: assert property (
    @(posedge clock) disable iff (reset) xip_req_i |-> (state_q == S_IDLE)
  );

endmodule

//--- source/spi_regs.sv
`timescale 1ns/1ps

module spi_regs #(
  parameter int unsigned SS_NUM = 8
) (
  input  logic                      clock,
  input  logic                      reset,
  input  spi_flash_pkg::wb_req_t    wb_req_i,
  output spi_flash_pkg::wb_rsp_t    wb_rsp_o,
  output spi_flash_pkg::spi_cmd_t   cmd_o,
  input  spi_flash_pkg::spi_stat_t  stat_i,
  output logic [SS_NUM-1:0]         ss_sel_o,
  output logic                      irq_o
);
  import spi_flash_pkg::*;

  apb_data_t                tx0_q;
  apb_data_t                tx1_q;
  apb_data_t                dat_q;
  apb_data_t                rd_data;
  logic [15:0]              divider_q;
  logic [SS_NUM-1:0]        ss_q;
  logic [CTRL_CHAR_LEN-1:0] char_len_q;
  logic                     ie_q;
  logic                     go_q;
  logic                     irq_q;
  logic                     ack_q;
  logic                     err_q;
  logic                     access;
  logic                     valid;
  logic                     wr;

  // New cycle only and not the one already answered
  assign access = wb_req_i.cyc && wb_req_i.stb && !ack_q && !err_q;
  assign wr     = access && valid && wb_req_i.we;

  // Only the five registers with full word lanes
  always_comb begin
    case (wb_req_i.adr)
      REG_RX0_TX0, REG_RX1_TX1, REG_CTRL, REG_DIVIDER, REG_SS:
        valid = (wb_req_i.sel == 4'hF);
      default: valid = 1'b0;
    endcase
  end

  // Read mux
  always_comb begin
    rd_data = '0;
    case (wb_req_i.adr)
      REG_RX0_TX0: rd_data = stat_i.rx_data[31:0];
      REG_RX1_TX1: rd_data = stat_i.rx_data[63:32];
      REG_CTRL: begin
        rd_data[CTRL_CHAR_LEN-1:0] = char_len_q;
        // Pending go counts as busy
        rd_data[CTRL_GO_BSY]       = stat_i.busy || go_q;
        rd_data[CTRL_IE]           = ie_q;
      end
      REG_DIVIDER: rd_data[15:0]       = divider_q;
      REG_SS:      rd_data[SS_NUM-1:0] = ss_q;
      default:     rd_data = '0;
    endcase
  end

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      ack_q      <= 1'b0;
      err_q      <= 1'b0;
      go_q       <= 1'b0;
      irq_q      <= 1'b0;
      ie_q       <= 1'b0;
      char_len_q <= '0;
      divider_q  <= '0;
      ss_q       <= '0;
    end else begin
      ack_q <= access && valid;
      err_q <= access && !valid;
      go_q  <= 1'b0;
      if (wr && wb_req_i.adr == REG_CTRL) begin
        char_len_q <= wb_req_i.dat[CTRL_CHAR_LEN-1:0];
        ie_q       <= wb_req_i.dat[CTRL_IE];
        // go while busy is dropped
        go_q       <= wb_req_i.dat[CTRL_GO_BSY] && !stat_i.busy && !go_q;
      end
      if (wr && wb_req_i.adr == REG_DIVIDER) divider_q <= wb_req_i.dat[15:0];
      if (wr && wb_req_i.adr == REG_SS) ss_q <= wb_req_i.dat[SS_NUM-1:0];
      // Done wins over a clearing access in the same cycle
      if (stat_i.done && ie_q) begin
        irq_q <= 1'b1;
      end else if (access) begin
        irq_q <= 1'b0;
      end
    end
  end

  // Transmit words and read return
  always_ff @(posedge clock) begin
    if (wr && wb_req_i.adr == REG_RX0_TX0) tx0_q <= wb_req_i.dat;
    if (wr && wb_req_i.adr == REG_RX1_TX1) tx1_q <= wb_req_i.dat;
    if (access) dat_q <= rd_data;
  end

  assign wb_rsp_o.dat = dat_q;
  assign wb_rsp_o.ack = ack_q;
  assign wb_rsp_o.err = err_q;

  assign cmd_o.go       = go_q;
  assign cmd_o.char_len = char_len_q;
  assign cmd_o.divider  = divider_q;
  assign cmd_o.tx_data  = {tx1_q, tx0_q};

  assign ss_sel_o = ss_q;
  assign irq_o    = irq_q;

  // Master still holds its request when the answer comes
  a_rsp_on_request: assert property (
    @(posedge clock) disable iff (reset)
    (wb_rsp_o.ack || wb_rsp_o.err) |-> (wb_req_i.cyc && wb_req_i.stb)
  );

endmodule

//--- source/spi_shifter.sv
`timescale 1ns/1ps

module spi_shifter #(
  parameter int unsigned SS_NUM = 8
) (
  input  logic                      clock,
  input  logic                      reset,
  input  spi_flash_pkg::spi_cmd_t   cmd_i,
  output spi_flash_pkg::spi_stat_t  stat_o,
  input  logic [SS_NUM-1:0]         ss_sel_i,
  output logic                      sck_o,
  output logic [SS_NUM-1:0]         ss_o,
  output logic                      mosi_o,
  input  logic                      miso_i
);
  import spi_flash_pkg::*;

  logic              busy_q;
  logic              sck_q;
  logic              done_q;
  logic              last_q;
  logic [15:0]       div_q;
  logic [15:0]       cnt_q;
  logic [6:0]        bits_q;
  logic [6:0]        len;
  logic [63:0]       tx_q;
  logic [63:0]       rx_q;
  logic [SS_NUM-1:0] ss_q;
  logic              start;
  logic              tick;
  logic              rise;
  logic              fall;

  assign start = cmd_i.go && !busy_q;
  // Zero and oversize lengths run the full 64 bits
  assign len   = (cmd_i.char_len == '0 || cmd_i.char_len > 7'd64) ? 7'd64 : cmd_i.char_len;

  // Half period ends when the counter runs out
  assign tick = busy_q && !last_q && (cnt_q == '0);
  assign rise = tick && !sck_q;
  assign fall = tick && sck_q;

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      busy_q <= 1'b0;
      sck_q  <= 1'b0;
      done_q <= 1'b0;
      last_q <= 1'b0;
      cnt_q  <= '0;
      bits_q <= '0;
      ss_q   <= '1;
    end else begin
      done_q <= 1'b0;
      // Selects are active low
      ss_q   <= ~ss_sel_i;
      if (start) begin
        busy_q <= 1'b1;
        sck_q  <= 1'b0;
        cnt_q  <= cmd_i.divider;
        bits_q <= len;
      end else if (last_q) begin
        // Close out one cycle after the final rising edge
        last_q <= 1'b0;
        busy_q <= 1'b0;
        sck_q  <= 1'b0;
        done_q <= 1'b1;
      end else if (tick) begin
        cnt_q <= div_q;
        sck_q <= !sck_q;
        if (rise) begin
          bits_q <= bits_q - 7'd1;
          if (bits_q == 7'd1) last_q <= 1'b1;
        end
      end else if (busy_q) begin
        cnt_q <= cnt_q - 16'd1;
      end
    end
  end

  // Transmit leaves from the MSB and receive fills from the LSB
  always_ff @(posedge clock) begin
    if (start) begin
      div_q <= cmd_i.divider;
      tx_q  <= cmd_i.tx_data << (7'd64 - len);
      rx_q  <= '0;
    end else begin
      if (rise) rx_q <= {rx_q[62:0], miso_i};
      if (fall) tx_q <= {tx_q[62:0], 1'b0};
    end
  end

  assign sck_o  = sck_q;
  assign mosi_o = busy_q && tx_q[63];
  assign ss_o   = ss_q;

  assign stat_o.busy    = busy_q;
  assign stat_o.done    = done_q;
  assign stat_o.rx_data = rx_q;

  // Register file only starts a transfer while the engine is idle
  a_go_when_idle: assert property (
    @(posedge clock) disable iff (reset) cmd_i.go |-> !busy_q
  );

endmodule

//--- source/spi_flash_top.sv
`timescale 1ns/1ps

module spi_flash_top #(
  parameter spi_flash_pkg::apb_data_t FLASH_BASE  = 32'h3000_0000,
  parameter spi_flash_pkg::apb_data_t FLASH_END   = 32'h3FFF_FFFF,
  parameter spi_flash_pkg::apb_data_t SPI_BASE    = 32'h1000_1000,
  parameter spi_flash_pkg::apb_data_t SPI_END     = 32'h1000_1FFF,
  parameter int unsigned              SS_NUM      = 8,
  parameter int unsigned              XIP_DIVIDER = 1
) (
  input  logic                     clock,
  input  logic                     reset,
  input  spi_flash_pkg::apb_data_t paddr_i,
  input  logic                     psel_i,
  input  logic                     penable_i,
  input  logic                     pwrite_i,
  input  spi_flash_pkg::apb_data_t pwdata_i,
  input  logic [3:0]               pstrb_i,
  output spi_flash_pkg::apb_data_t prdata_o,
  output logic                     pready_o,
  output logic                     pslverr_o,
  output logic                     sck_o,
  output logic [SS_NUM-1:0]        ss_o,
  output logic                     mosi_o,
  input  logic                     miso_i,
  output logic                     irq_o
);
  import spi_flash_pkg::*;

  wb_req_t           wb_req;
  wb_req_t           seq_req;
  wb_rsp_t           wb_rsp;
  spi_cmd_t          cmd;
  spi_stat_t         stat;
  logic              xip_req;
  logic              xip_done;
  logic [23:0]       xip_addr;
  apb_data_t         xip_data;
  logic [SS_NUM-1:0] ss_sel;

  // APB decode and path select
  apb_front #(
    .FLASH_BASE(FLASH_BASE),
    .FLASH_END (FLASH_END),
    .SPI_BASE  (SPI_BASE),
    .SPI_END   (SPI_END)
  ) u_front (
    .clock, .reset, .paddr_i, .pwdata_i, .psel_i, .penable_i, .pwrite_i, .pstrb_i,
    .prdata_o, .pready_o, .pslverr_o,
    .wb_req_o  (wb_req),
    .wb_rsp_i  (wb_rsp),
    .xip_req_o (xip_req),
    .xip_addr_o(xip_addr),
    .seq_req_i (seq_req),
    .xip_done_i(xip_done),
    .xip_data_i(xip_data)
  );

  // Flash read sequence master
  xip_sequencer #(.XIP_DIVIDER(XIP_DIVIDER)) u_seq (
    .clock, .reset,
    .xip_req_i (xip_req),
    .xip_addr_i(xip_addr),
    .wb_req_o  (seq_req),
    .wb_rsp_i  (wb_rsp),
    .xip_done_o(xip_done),
    .xip_data_o(xip_data)
  );

  spi_regs #(.SS_NUM(SS_NUM)) u_regs (
    .clock, .reset,
    .wb_req_i(wb_req),
    .wb_rsp_o(wb_rsp),
    .cmd_o   (cmd),
    .stat_i  (stat),
    .ss_sel_o(ss_sel),
    .irq_o
  );

  spi_shifter #(.SS_NUM(SS_NUM)) u_shift (
    .clock, .reset,
    .cmd_i   (cmd),
    .stat_o  (stat),
    .ss_sel_i(ss_sel),
    .sck_o, .ss_o, .mosi_o, .miso_i
  );

endmodule

//--- verification/spi_flash_model.sv
`timescale 1ns/1ps

module spi_flash_model (
  input  logic sck_i,
  input  logic ss_i,
  input  logic mosi_i,
  output logic miso_o
);
  import spi_flash_pkg::*;

  // Header shift, opcode in the top byte
  logic [31:0] cmd_q     = '0;
  logic [23:0] next_addr = '0;
  logic [7:0]  out_byte  = '0;
  logic [2:0]  bit_pos   = '0;
  logic        sck_q     = 1'b0;
  int unsigned bit_cnt   = 0;

  // Stored pattern, low address byte scrambled
  function automatic logic [7:0] byte_at(input logic [23:0] addr);
    return addr[7:0] ^ 8'h5A;
  endfunction

  initial miso_o = 1'b0;

  // ss_i is active low
  always @(sck_i or ss_i) begin
    if (ss_i) begin
      // Deselected, next frame starts fresh
      bit_cnt   = 0;
      bit_pos   = '0;
      next_addr = '0;
      miso_o    = 1'b0;
    end else if (sck_i && !sck_q) begin
      // Rising sck samples opcode and address, MSB first
      if (bit_cnt < 32) begin
        cmd_q   = {cmd_q[30:0], mosi_i};
        bit_cnt = bit_cnt + 1;
        if (bit_cnt == 32) next_addr = cmd_q[23:0];
      end
    end else if (!sck_i && sck_q && bit_cnt == 32 && cmd_q[31:24] == FLASH_READ_CMD) begin
      // Falling sck puts the next data bit out
      if (bit_pos == 3'd0) begin
        out_byte  = byte_at(next_addr);
        next_addr = next_addr + 24'd1;
      end
      miso_o   = out_byte[7];
      out_byte = {out_byte[6:0], 1'b0};
      bit_pos  = bit_pos + 3'd1;
    end
    sck_q = sck_i;
  end

endmodule

//--- verification/tb_spi_flash.sv
`timescale 1ns/1ps

module tb_spi_flash;
  import spi_flash_pkg::*;

  localparam int        SS_NUM    = 8;
  localparam int        TIMEOUT   = 2000;
  localparam apb_data_t CTRL_ADDR = 32'h1000_1010;

  logic              clock = 1'b0;
  logic              reset;
  apb_data_t         paddr;
  apb_data_t         pwdata;
  apb_data_t         prdata;
  logic              psel;
  logic              penable;
  logic              pwrite;
  logic [3:0]        pstrb;
  logic              pready;
  logic              pslverr;
  logic              sck;
  logic [SS_NUM-1:0] ss;
  logic              mosi;
  logic              miso;
  logic              irq;
  int                errors;
  int                timeouts;
  int                seed;

  spi_flash_top #(.SS_NUM(SS_NUM)) dut0 (
    .clock,
    .reset,
    .paddr_i  (paddr),
    .psel_i   (psel),
    .penable_i(penable),
    .pwrite_i (pwrite),
    .pwdata_i (pwdata),
    .pstrb_i  (pstrb),
    .prdata_o (prdata),
    .pready_o (pready),
    .pslverr_o(pslverr),
    .sck_o    (sck),
    .ss_o     (ss),
    .mosi_o   (mosi),
    .miso_i   (miso),
    .irq_o    (irq)
  );

  // Flash on select line 0
  spi_flash_model flash0 (
    .sck_i (sck),
    .ss_i  (ss[0]),
    .mosi_i(mosi),
    .miso_o(miso)
  );

  // 4 ns period
  always #2 clock = ~clock;

  task automatic check_word(input string name, input apb_data_t exp, input apb_data_t act);
    if (exp !== act) begin
      $display("[ERROR] %s: expected %h, actual %h", name, exp, act);
      errors++;
    end
  endtask

  task automatic check_err(input string name, input logic exp, input logic act);
    if (exp !== act) begin
      $display("[ERROR] %s: pslverr expected %b, actual %b", name, exp, act);
      errors++;
    end
  endtask

  task automatic check_irq(input string name, input logic exp, input logic act);
    if (exp !== act) begin
      $display("[ERROR] %s: irq expected %b, actual %b", name, exp, act);
      errors++;
    end
  endtask

  task automatic check_ss(input string name, input logic [SS_NUM-1:0] exp,
                          input logic [SS_NUM-1:0] act);
    if (exp !== act) begin
      $display("[ERROR] %s: ss expected %h, actual %h", name, exp, act);
      errors++;
    end
  endtask

  // Random bus noise while psel is low
  task automatic idle_gap();
    int n;
    n = $unsigned($random(seed)) % 4;
    repeat (n) begin
      @(negedge clock);
      paddr  = $random(seed);
      pwdata = $random(seed);
    end
  endtask

  // One APB transfer, setup then access until pready
  task automatic apb_access(input logic write, input apb_data_t addr, input apb_data_t data,
                            output apb_data_t rdata, output logic err);
    int cycles;
    @(negedge clock);
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = write;
    paddr   = addr;
    pwdata  = data;
    pstrb   = 4'hF;
    @(negedge clock);
    penable = 1'b1;
    cycles  = 0;
    @(negedge clock);
    while (!pready && cycles < TIMEOUT) begin
      @(negedge clock);
      cycles++;
    end
    if (!pready) begin
      $display("Timeout: no pready for the APB access to %h", addr);
      timeouts++;
    end
    rdata = prdata;
    err   = pslverr;
    // Transfer ends on the next rising edge
    @(negedge clock);
    psel    = 1'b0;
    penable = 1'b0;
  endtask

  task automatic wait_irq();
    int cycles;
    cycles = 0;
    while (!irq && cycles < TIMEOUT) begin
      @(negedge clock);
      cycles++;
    end
    if (!irq) begin
      $display("Timeout: irq never rose after a direct transfer was started");
      timeouts++;
    end
  endtask

  initial begin
    string     line;
    string     name;
    byte       kind;
    apb_data_t addr;
    apb_data_t wdata;
    apb_data_t expd;
    apb_data_t rdata;
    logic      err;
    logic      irq_clear_due;
    int        fd;
    int        count;
    int        op;
    reset         = 1'b1;
    psel          = 1'b0;
    penable       = 1'b0;
    pwrite        = 1'b0;
    paddr         = '0;
    pwdata        = '0;
    pstrb         = 4'h0;
    seed          = 32'h782d_f4e5;
    errors        = 0;
    timeouts      = 0;
    op            = 0;
    irq_clear_due = 1'b0;
    repeat (8) @(posedge clock);
    @(negedge clock);
    reset = 1'b0;
    fd = $fopen("verification/spi_flash_testdata.txt", "r");
    if (fd == 0) begin
      $display("Could not open the test data file");
      errors++;
    end else begin
      while ($fgets(line, fd) != 0) begin
        // Skip blank and comment lines
        if (line.len() < 2 || line[0] == "#") continue;
        count = $sscanf(line, "%c %h %h %h", kind, addr, wdata, expd);
        if (count != 4) continue;
        op++;
        name = $sformatf("op%0d %c %h", op, kind, addr);
        idle_gap();
        case (kind)
          "W": begin
            apb_access(1'b1, addr, wdata, rdata, err);
            check_err(name, 1'b0, err);
          end
          "R": begin
            apb_access(1'b0, addr, wdata, rdata, err);
            check_err(name, 1'b0, err);
            check_word(name, expd, rdata);
          end
          "X": begin
            apb_access(1'b0, addr, wdata, rdata, err);
            check_err(name, 1'b0, err);
            check_word(name, expd, rdata);
            // All selects released after the sequence
            check_ss(name, '1, ss);
          end
          "E": begin
            apb_access(1'b1, addr, wdata, rdata, err);
            check_err(name, 1'b1, err);
          end
          default: begin
            $display("Unknown operation kind in test data line %0d", op);
            errors++;
          end
        endcase
        // Any register access drops a pending irq
        if (irq_clear_due) begin
          check_irq(name, 1'b0, irq);
          irq_clear_due = 1'b0;
        end
        // Direct start with ie set, irq marks the end
        if (kind == "W" && addr == CTRL_ADDR && wdata[CTRL_GO_BSY] && wdata[CTRL_IE]) begin
          wait_irq();
          irq_clear_due = 1'b1;
        end
      end
      $fclose(fd);
    end
    if (op == 0) begin
      $display("No operations were read from the test data file");
      errors++;
    end
    $display("Checks done after %0d operations: %0d errors, %0d timeouts", op, errors,
             timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

//--- verification/spi_flash_testdata.txt
# kind address write_data expected_data, all hex
# W write, R read and compare, X flash window read, E write that must fail
W 10001014 00000003 00000000
R 10001014 00000000 00000003
W 10001018 000000A4 00000000
R 10001018 00000000 000000A4
W 10001018 00000001 00000000
W 10001000 03000040 00000000
W 10001010 00001120 00000000
R 10001000 00000000 00000000
W 10001010 00001120 00000000
R 10001000 00000000 1A1B1819
W 10001018 00000000 00000000
X 30000000 00000000 5A5B5859
X 30000124 00000000 7E7F7C7D
X 30ABCDF0 00000000 AAABA8A9
X 30001080 00000000 DADBD8D9
X 300000FE 00000000 A4A55A5B
E 20000000 00000000 00000000
E 10001008 12345678 00000000
E 10001020 00000000 00000000
E 30000010 DEADBEEF 00000000

//--- tb.f
source/spi_flash_pkg.sv
source/apb_front.sv
source/xip_sequencer.sv
source/spi_regs.sv
source/spi_shifter.sv
source/spi_flash_top.sv
verification/spi_flash_model.sv
verification/tb_spi_flash.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f tb.f --top-module tb_spi_flash -o sim_tb
./obj_dir/sim_tb | tee sim.log
if grep -q "Result: FAILED" sim.log; then
  exit 1
fi
if ! grep -q "Result: PASSED" sim.log; then
  exit 1
fi
